/* design/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------

// Width of a register and of a memory word
`define RV_DATA_W 32

// Width of the program counter
`define RV_IADDR_W 32

// ----------------------------------------
// Data memory geometry
// ----------------------------------------

// Number of 32-bit words in the data RAM
`define RV_DMEM_WORDS 1024

// Byte address bits seen by the data RAM
// Upper address bits are dropped so accesses wrap around the array
// Two of these bits select the byte lane and the rest index the word
`define RV_DADDR_W 12

`endif

/* design/rv_types_pkg.sv */
package rv_types_pkg;

    // ----------------------------------------
    // Memory access size
    // ----------------------------------------

    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,       // 8-bit access
        ACC_HALF = 2'b01,       // 16-bit access, address bit 0 clear
        ACC_WORD = 2'b10        // 32-bit access, address bits 1:0 clear
    } data_access_e;

    // ----------------------------------------
    // Destination register source
    // ----------------------------------------

    // Code 2'b11 has no source and writes zero
    typedef enum logic [1:0] {
        SEL_ALU = 2'b00,        // ALU result
        SEL_MEM = 2'b01,        // Extended load data
        SEL_PC4 = 2'b10         // Return address
    } wr_data_sel_e;

    // ----------------------------------------
    // Memory adapter FSM
    // ----------------------------------------

    typedef enum logic {
        ST_IDLE      = 1'b0,    // Ready for a new access
        ST_LOAD_WAIT = 1'b1     // RAM read issued, data arrives this cycle
    } adapter_state_e;

endpackage

/* design/data_mem_adapter.sv */
`timescale 1ns/1ps

`include "rv_consts.svh"

module data_mem_adapter (
    input  logic                          i_clock,        // Clock
    input  logic                          i_arst_n,       // Async reset, active low

    // Access request from the stage
    input  logic [`RV_DADDR_W-1:0]        i_addr,         // Byte address
    input  rv_types_pkg::data_access_e    i_access,       // Access size
    input  logic                          i_unsigned,     // Zero extend on load
    input  logic                          i_wr_en,        // Store, already gated with valid
    input  logic                          i_rd_en,        // Load, already gated with valid
    input  logic [`RV_DATA_W-1:0]         i_wr_data,      // Store data, low bits used
    output logic [`RV_DATA_W-1:0]         o_rd_data,      // Extended load data
    output logic                          o_busy,         // Load issued, hold inputs
    output logic                          o_align_error,  // Misaligned request

    // RAM side
    input  logic [`RV_DATA_W-1:0]         i_mem_rdata,    // Registered RAM word
    output logic [`RV_DADDR_W-3:0]        o_mem_addr,     // Word index
    output logic                          o_mem_we,       // Write strobe
    output logic [3:0]                    o_mem_be,       // Byte lane enables
    output logic [`RV_DATA_W-1:0]         o_mem_wdata,    // Lane aligned store data
    output logic                          o_mem_re        // Read strobe
);

    import rv_types_pkg::*;

    // ----------------------------------------
    // Address split and alignment check
    // ----------------------------------------

    logic [1:0]     byte_ofs;       // Lane within the word
    logic           misaligned;     // Size does not fit the offset
    logic           load_go;        // Aligned load request

    assign byte_ofs   = i_addr[1:0];
    assign o_mem_addr = i_addr[`RV_DADDR_W-1:2];

    always_comb begin
        case (i_access)
            ACC_BYTE: misaligned = 1'b0;            // Any offset is fine
            ACC_HALF: misaligned = byte_ofs[0];     // Needs an even address
            default:  misaligned = |byte_ofs;       // Word and unused code
        endcase
    end

    // Flag only real requests so idle cycles stay clean
    assign o_align_error = (i_wr_en | i_rd_en) & misaligned;
    assign load_go       = i_rd_en & ~misaligned;

    // ----------------------------------------
    // Store path
    // ----------------------------------------

    always_comb begin
        case (i_access)
            ACC_BYTE: begin
                o_mem_be    = 4'b0001 << byte_ofs;          // One lane
                o_mem_wdata = {4{i_wr_data[7:0]}};          // Byte in every lane
            end
            ACC_HALF: begin
                o_mem_be    = byte_ofs[1] ? 4'b1100 : 4'b0011;
                o_mem_wdata = {2{i_wr_data[15:0]}};         // Half in both halves
            end
            default: begin
                o_mem_be    = 4'b1111;                      // Full word
                o_mem_wdata = i_wr_data;
            end
        endcase
    end

    // A misaligned store touches nothing
    assign o_mem_we = i_wr_en & ~misaligned;

    // ----------------------------------------
    // Load FSM
    // ----------------------------------------

    adapter_state_e state;
    adapter_state_e state_nxt;

    // Read goes out only from idle, the wait cycle consumes the data
    assign o_mem_re = load_go & (state == ST_IDLE);
    assign o_busy   = o_mem_re;                     // Stall during the issue cycle

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:      if (o_mem_re) state_nxt = ST_LOAD_WAIT;
            ST_LOAD_WAIT: state_nxt = ST_IDLE;      // Data is back, done
            default:      state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    // Load attributes captured with the read strobe
    logic [1:0]     rd_ofs;
    data_access_e   rd_access;
    logic           rd_unsigned;

    always_ff @(posedge i_clock) begin
        if (o_mem_re) begin
            rd_ofs      <= byte_ofs;
            rd_access   <= i_access;
            rd_unsigned <= i_unsigned;
        end
    end

    // ----------------------------------------
    // Lane extract and extend
    // ----------------------------------------

    logic [7:0]     rd_byte;
    logic [15:0]    rd_half;

    assign rd_byte = i_mem_rdata[8*rd_ofs +: 8];        // Pick the addressed byte
    assign rd_half = i_mem_rdata[16*rd_ofs[1] +: 16];   // Low or high half

    always_comb begin
        case (rd_access)
            ACC_BYTE:
                o_rd_data = {{(`RV_DATA_W-8){rd_byte[7] & ~rd_unsigned}}, rd_byte};
            ACC_HALF:
                o_rd_data = {{(`RV_DATA_W-16){rd_half[15] & ~rd_unsigned}}, rd_half};
            default:
                o_rd_data = i_mem_rdata;                // Word needs no extension
        endcase
    end

endmodule

/* design/data_mem.sv */
`timescale 1ns/1ps

`include "rv_consts.svh"

module data_mem (
    input  logic                      i_clock,    // Clock
    input  logic [`RV_DADDR_W-3:0]    i_addr,     // Word index
    input  logic                      i_we,       // Write strobe
    input  logic [3:0]                i_be,       // Byte lane enables
    input  logic [`RV_DATA_W-1:0]     i_wdata,    // Lane aligned write data
    input  logic                      i_re,       // Read strobe
    output logic [`RV_DATA_W-1:0]     o_rdata     // Registered read word
);

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    // Contents come up undefined, software must write before reading
    logic [`RV_DATA_W-1:0] mem [`RV_DMEM_WORDS];

    // ----------------------------------------
    // Byte masked write
    // ----------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_we) begin
            for (int b = 0; b < 4; b++) begin
                if (i_be[b])
                    mem[i_addr][8*b +: 8] <= i_wdata[8*b +: 8];   // Only enabled lanes
            end
        end
    end

    // ----------------------------------------
    // Registered read
    // ----------------------------------------

    // One cycle latency
    // Output keeps the last word while no read is strobed
    always_ff @(posedge i_clock) begin
        if (i_re)
            o_rdata <= mem[i_addr];
    end

    // Reads and writes never share a cycle in this stage
    // A write followed by a read next cycle returns the new word
    // since the array has already been updated at that edge
    // The RAM maps onto a single port block with byte write enables

endmodule

/* design/stage_mem.sv */
`timescale 1ns/1ps

`include "rv_consts.svh"

module stage_mem (
    input  logic                          i_clock,        // Clock
    input  logic                          i_arst_n,       // Async reset, active low

    // Executed instruction
    input  logic                          i_valid,        // Instruction is valid
    input  logic [`RV_IADDR_W-1:0]        i_pc,           // Instruction address
    input  logic [`RV_DATA_W-1:0]         i_result,       // ALU result, also the address
    input  logic [`RV_DATA_W-1:0]         i_data_b,       // Store data
    input  logic                          i_mem_wr_en,    // Store request
    input  logic                          i_mem_rd_en,    // Load request
    input  rv_types_pkg::data_access_e    i_mem_access,   // Access size
    input  logic                          i_mem_unsigned, // Zero extend load
    input  rv_types_pkg::wr_data_sel_e    i_reg_wr_sel,   // Destination source

    // Data memory port
    input  logic [`RV_DATA_W-1:0]         i_mem_rdata,    // RAM read word
    output logic [`RV_DADDR_W-3:0]        o_mem_addr,     // Word index
    output logic                          o_mem_we,       // Write strobe
    output logic [3:0]                    o_mem_be,       // Byte enables
    output logic [`RV_DATA_W-1:0]         o_mem_wdata,    // Store data in lanes
    output logic                          o_mem_re,       // Read strobe

    // Toward the pipeline
    output logic                          o_hazard,       // Hold inputs one more cycle
    output logic                          o_align_error,  // Misaligned access
    output logic [`RV_DATA_W-1:0]         o_reg_wr_data   // Destination register data
);

    import rv_types_pkg::*;

    // ----------------------------------------
    // Memory adapter
    // ----------------------------------------

    logic [`RV_DATA_W-1:0]  load_data;      // Extended load result
    logic                   adapter_busy;   // Load in its issue cycle

    data_mem_adapter u_adapter (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_addr         (i_result[`RV_DADDR_W-1:0]),   // Upper bits wrap
        .i_access       (i_mem_access),
        .i_unsigned     (i_mem_unsigned),
        .i_wr_en        (i_mem_wr_en & i_valid),        // Bubbles never write
        .i_rd_en        (i_mem_rd_en & i_valid),        // Bubbles never read
        .i_wr_data      (i_data_b),
        .o_rd_data      (load_data),
        .o_busy         (adapter_busy),
        .o_align_error  (o_align_error),
        .i_mem_rdata    (i_mem_rdata),
        .o_mem_addr     (o_mem_addr),
        .o_mem_we       (o_mem_we),
        .o_mem_be       (o_mem_be),
        .o_mem_wdata    (o_mem_wdata),
        .o_mem_re       (o_mem_re)
    );

    assign o_hazard = adapter_busy;

    // ----------------------------------------
    // Return address
    // ----------------------------------------

    logic [`RV_IADDR_W-1:0] pc_plus4;
    logic [`RV_DATA_W-1:0]  pc_plus4_ext;   // Widened to the register size

    assign pc_plus4 = i_pc + `RV_IADDR_W'(4);

    always_comb begin
        pc_plus4_ext = '0;
        pc_plus4_ext[`RV_IADDR_W-1:0] = pc_plus4;
    end

    // ----------------------------------------
    // Write back select
    // ----------------------------------------

    // Not qualified by valid, the register file decides that
    always_comb begin
        case (i_reg_wr_sel)
            SEL_ALU: o_reg_wr_data = i_result;
            SEL_MEM: o_reg_wr_data = load_data;         // Valid in the second load cycle
            SEL_PC4: o_reg_wr_data = pc_plus4_ext;
            default: o_reg_wr_data = '0;                // Unused code
        endcase
    end

endmodule

/* design/mem_subsys_top.sv */
`timescale 1ns/1ps

`include "rv_consts.svh"

module mem_subsys_top (
    input  logic                          i_clock,        // Clock
    input  logic                          i_arst_n,       // Async reset, active low
    input  logic                          i_valid,        // Instruction is valid
    input  logic [`RV_IADDR_W-1:0]        i_pc,           // Instruction address
    input  logic [`RV_DATA_W-1:0]         i_result,       // ALU result and address
    input  logic [`RV_DATA_W-1:0]         i_data_b,       // Store data
    input  logic                          i_mem_wr_en,    // Store request
    input  logic                          i_mem_rd_en,    // Load request
    input  rv_types_pkg::data_access_e    i_mem_access,   // Access size
    input  logic                          i_mem_unsigned, // Zero extend load
    input  rv_types_pkg::wr_data_sel_e    i_reg_wr_sel,   // Destination source
    output logic                          o_hazard,       // Stall request
    output logic [`RV_DATA_W-1:0]         o_reg_wr_data,  // Destination register data
    output logic                          o_align_error   // Misaligned access
);

    // ----------------------------------------
    // Stage to RAM wires
    // ----------------------------------------

    logic [`RV_DADDR_W-3:0]  mem_addr;
    logic                    mem_we;
    logic [3:0]              mem_be;
    logic [`RV_DATA_W-1:0]   mem_wdata;
    logic                    mem_re;
    logic [`RV_DATA_W-1:0]   mem_rdata;

    stage_mem u_stage_mem (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_valid        (i_valid),
        .i_pc           (i_pc),
        .i_result       (i_result),
        .i_data_b       (i_data_b),
        .i_mem_wr_en    (i_mem_wr_en),
        .i_mem_rd_en    (i_mem_rd_en),
        .i_mem_access   (i_mem_access),
        .i_mem_unsigned (i_mem_unsigned),
        .i_reg_wr_sel   (i_reg_wr_sel),
        .i_mem_rdata    (mem_rdata),
        .o_mem_addr     (mem_addr),
        .o_mem_we       (mem_we),
        .o_mem_be       (mem_be),
        .o_mem_wdata    (mem_wdata),
        .o_mem_re       (mem_re),
        .o_hazard       (o_hazard),
        .o_align_error  (o_align_error),
        .o_reg_wr_data  (o_reg_wr_data)
    );

    // Data RAM
    data_mem u_data_mem (
        .i_clock        (i_clock),
        .i_addr         (mem_addr),
        .i_we           (mem_we),
        .i_be           (mem_be),
        .i_wdata        (mem_wdata),
        .i_re           (mem_re),
        .o_rdata        (mem_rdata)     // One cycle after mem_re
    );

endmodule

/* dv/tb_mem_model.svh */
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// ----------------------------------------
// Reference data memory
// ----------------------------------------

logic [`RV_DATA_W-1:0] ref_mem [`RV_DMEM_WORDS];   // Mirrors the DUT RAM

// Word slot of a byte address, upper bits wrap
function automatic int word_slot(input logic [`RV_DATA_W-1:0] addr);
    return int'(addr[`RV_DADDR_W-1:2]);
endfunction

// Bytes moved by one access
function automatic int access_bytes(input data_access_e acc);
    int n;
    case (acc)
        ACC_BYTE: n = 1;
        ACC_HALF: n = 2;
        default:  n = 4;
    endcase
    return n;
endfunction

// Initial content of each word, unique for every word index
function automatic logic [`RV_DATA_W-1:0] fill_word(input int idx);
    return (32'(idx) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
endfunction

// Offset must be a multiple of the access size
function automatic logic ref_aligned(input logic [`RV_DATA_W-1:0] addr, input data_access_e acc);
    return (int'(addr[1:0]) % access_bytes(acc)) == 0;
endfunction

// Copy the low bytes of the store data into consecutive lanes
function automatic void ref_store(input logic [`RV_DATA_W-1:0] addr,
                                  input logic [`RV_DATA_W-1:0] data,
                                  input data_access_e          acc);
    int idx;
    int lane;
    idx = word_slot(addr);
    for (int i = 0; i < access_bytes(acc); i++) begin
        lane = int'(addr[1:0]) + i;
        ref_mem[idx][8*lane +: 8] = data[8*i +: 8];
    end
endfunction

// Gather the addressed bytes and extend to a full word
function automatic logic [`RV_DATA_W-1:0] ref_load(input logic [`RV_DATA_W-1:0] addr,
                                                   input data_access_e          acc,
                                                   input logic                  uns);
    logic [`RV_DATA_W-1:0] word;
    logic [`RV_DATA_W-1:0] val;
    int                    n;
    int                    lane;
    word = ref_mem[word_slot(addr)];
    n    = access_bytes(acc);
    val  = '0;
    for (int i = 0; i < n; i++) begin
        lane = int'(addr[1:0]) + i;
        val[8*i +: 8] = word[8*lane +: 8];
    end
    if (!uns && n < 4 && val[8*n-1]) begin
        for (int i = n; i < 4; i++)
            val[8*i +: 8] = 8'hff;      // Sign fill
    end
    return val;
endfunction

// Destination register value for each select code
function automatic logic [`RV_DATA_W-1:0] ref_wb(input wr_data_sel_e          sel,
                                                 input logic [`RV_DATA_W-1:0]  result,
                                                 input logic [`RV_IADDR_W-1:0] pc,
                                                 input logic [`RV_DATA_W-1:0]  ld);
    logic [`RV_DATA_W-1:0] val;
    case (sel)
        SEL_ALU: val = result;
        SEL_MEM: val = ld;
        SEL_PC4: val = pc + 32'd4;      // Wraps at the top of the address space
        default: val = '0;
    endcase
    return val;
endfunction

`endif

/* dv/tb_mem_subsys.sv */
`timescale 1ns/1ps

`include "rv_consts.svh"

module tb_mem_subsys;

    import rv_types_pkg::*;

    localparam int HAZ_TIMEOUT = 8;     // Stall cycles allowed per access
    localparam int MIX_OPS     = 400;

    // ----------------------------------------
    // DUT and clock
    // ----------------------------------------

    logic                    i_clock = 1'b0;
    logic                    i_arst_n;
    logic                    i_valid;
    logic [`RV_IADDR_W-1:0]  i_pc;
    logic [`RV_DATA_W-1:0]   i_result;
    logic [`RV_DATA_W-1:0]   i_data_b;
    logic                    i_mem_wr_en;
    logic                    i_mem_rd_en;
    data_access_e            i_mem_access;
    logic                    i_mem_unsigned;
    wr_data_sel_e            i_reg_wr_sel;
    logic                    o_hazard;
    logic [`RV_DATA_W-1:0]   o_reg_wr_data;
    logic                    o_align_error;

    mem_subsys_top i_mem_subsys_top (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_valid(i_valid), .i_pc(i_pc),
        .i_result(i_result), .i_data_b(i_data_b), .i_mem_wr_en(i_mem_wr_en),
        .i_mem_rd_en(i_mem_rd_en), .i_mem_access(i_mem_access),
        .i_mem_unsigned(i_mem_unsigned), .i_reg_wr_sel(i_reg_wr_sel),
        .o_hazard(o_hazard), .o_reg_wr_data(o_reg_wr_data), .o_align_error(o_align_error)
    );

    always #5 i_clock = ~i_clock;       // 10 ns period

    `include "tb_mem_model.svh"

    // Expectations travel with the inputs they belong to
    logic                  chk_align;
    logic                  chk_haz;
    logic                  chk_wb;
    logic                  exp_align;
    logic [`RV_DATA_W-1:0] exp_wb;
    int                    n_checks = 0;
    int                    n_errors = 0;
    int                    n_tests  = 0;

    // ----------------------------------------
    // Compare process
    // ----------------------------------------

    // Outputs are settled mid cycle
    always @(negedge i_clock) begin
        if (i_arst_n) begin
            if (chk_align) begin
                n_checks++;
                if (o_align_error !== exp_align) begin
                    $display("error: o_align_error = %h, expected %h", o_align_error, exp_align);
                    n_errors++;
                end
            end
            if (chk_haz) begin
                n_checks++;
                if (o_hazard !== 1'b0) begin
                    $display("error: o_hazard = %h, expected %h", o_hazard, 1'b0);
                    n_errors++;
                end
            end
            if (chk_wb && !o_hazard) begin      // Load data only once the stall ends
                n_checks++;
                if (o_reg_wr_data !== exp_wb) begin
                    $display("error: o_reg_wr_data = %h, expected %h (i_result %h)",
                             o_reg_wr_data, exp_wb, i_result);
                    n_errors++;
                end
            end
        end
    end

    // ----------------------------------------
    // Driver
    // ----------------------------------------

    // One instruction, held until o_hazard drops
    task automatic run_op(input logic                   valid,
                          input logic                   wr,
                          input logic                   rd,
                          input logic [`RV_DATA_W-1:0]  addr,
                          input logic [`RV_DATA_W-1:0]  data,
                          input data_access_e           acc,
                          input logic                   uns,
                          input wr_data_sel_e           sel,
                          input logic [`RV_IADDR_W-1:0] pc);
        logic                  ok;
        logic                  is_load;
        logic [`RV_DATA_W-1:0] ld;
        int                    high;
        ok      = ref_aligned(addr, acc);
        is_load = valid && rd && ok;
        ld      = is_load ? ref_load(addr, acc, uns) : '0;
        @(posedge i_clock);
        i_valid        <= valid;
        i_mem_wr_en    <= wr;
        i_mem_rd_en    <= rd;
        i_result       <= addr;
        i_data_b       <= data;
        i_mem_access   <= acc;
        i_mem_unsigned <= uns;
        i_reg_wr_sel   <= sel;
        i_pc           <= pc;
        chk_align      <= 1'b1;
        exp_align      <= valid && (wr || rd) && !ok;
        chk_haz        <= !is_load;             // Load stall is counted below
        chk_wb         <= (sel != SEL_MEM) || is_load;
        exp_wb         <= ref_wb(sel, addr, pc, ld);
        if (valid && wr && ok)
            ref_store(addr, data, acc);
        high = 0;
        @(negedge i_clock);
        while (o_hazard && high < HAZ_TIMEOUT) begin
            high++;
            @(negedge i_clock);
        end
        if (o_hazard) begin
            n_errors++;
            $display("timeout: o_hazard stayed high for %0d cycles on address %h",
                     HAZ_TIMEOUT, addr);
            $display("TEST FAIL");
            $finish;
        end else begin
            n_checks++;
            if (high != (is_load ? 1 : 0)) begin
                $display("error: o_hazard high cycles = %h, expected %h", high, is_load ? 1 : 0);
                n_errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        n_tests++;
        $display("test %0s done with %0d errors", name, n_errors - err_start);
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    initial begin
        logic [`RV_DATA_W-1:0]  addr;
        logic [`RV_DATA_W-1:0]  data;
        logic [`RV_IADDR_W-1:0] pc;
        data_access_e           acc;
        wr_data_sel_e           sel;
        logic                   valid;
        int                     kind;
        int                     err_start;

        void'($urandom(43));
        i_arst_n <= 1'b0;
        i_valid <= 1'b0;
        i_pc <= '0;
        i_result <= '0;
        i_data_b <= '0;
        i_mem_wr_en <= 1'b0;
        i_mem_rd_en <= 1'b0;
        i_mem_access <= ACC_WORD;
        i_mem_unsigned <= 1'b0;
        i_reg_wr_sel <= SEL_ALU;
        chk_align <= 1'b0;
        chk_haz <= 1'b0;
        chk_wb <= 1'b0;
        exp_align <= 1'b0;
        exp_wb <= '0;
        repeat (4) @(posedge i_clock);
        i_arst_n <= 1'b1;

        // Idle after reset, then give every word a known value
        err_start = n_errors;
        run_op(1'b0, 1'b0, 1'b0, 32'h0, 32'h0, ACC_WORD, 1'b0, SEL_ALU, 32'h0);
        for (int idx = 0; idx < `RV_DMEM_WORDS; idx++)
            run_op(1'b1, 1'b1, 1'b0, 32'(idx) << 2, fill_word(idx), ACC_WORD, 1'b0, SEL_ALU, 32'h0);
        report_test("reset_and_fill", err_start);

        err_start = n_errors;
        for (int i = 0; i < 16; i++) begin
            addr = $urandom & ~32'h3;
            run_op(1'b1, 1'b1, 1'b0, addr, $urandom, ACC_WORD, 1'b0, SEL_ALU, 32'h0);
            run_op(1'b1, 1'b0, 1'b1, addr, 32'h0, ACC_WORD, 1'b0, SEL_MEM, 32'h0);
        end
        report_test("word_round_trip", err_start);

        // Byte lanes in one word, halves in the next
        err_start = n_errors;
        addr = $urandom & ~32'h7;
        for (int ofs = 0; ofs < 4; ofs++) begin
            data = ofs[0] ? ($urandom & ~32'h80) : ($urandom | 32'h80);
            run_op(1'b1, 1'b1, 1'b0, addr + 32'(ofs), data, ACC_BYTE, 1'b0, SEL_ALU, 32'h0);
        end
        run_op(1'b1, 1'b1, 1'b0, addr + 32'd4, $urandom | 32'h8000, ACC_HALF, 1'b0, SEL_ALU, 32'h0);
        run_op(1'b1, 1'b1, 1'b0, addr + 32'd6, $urandom & ~32'h8000, ACC_HALF, 1'b0, SEL_ALU, 32'h0);
        for (int ofs = 0; ofs < 8; ofs++) begin
            for (int u = 0; u < 2; u++) begin
                run_op(1'b1, 1'b0, 1'b1, addr + 32'(ofs), 32'h0, ACC_BYTE, 1'(u), SEL_MEM, 32'h0);
                if (ofs % 2 == 0)
                    run_op(1'b1, 1'b0, 1'b1, addr + 32'(ofs), 32'h0, ACC_HALF, 1'(u), SEL_MEM, 32'h0);
            end
            if (ofs % 4 == 0)
                run_op(1'b1, 1'b0, 1'b1, addr + 32'(ofs), 32'h0, ACC_WORD, 1'b0, SEL_MEM, 32'h0);
        end
        report_test("sub_word", err_start);

        // Misaligned stores must leave the word alone
        err_start = n_errors;
        addr = $urandom & ~32'h3;
        data = $urandom;
        run_op(1'b1, 1'b1, 1'b0, addr, data, ACC_WORD, 1'b0, SEL_ALU, 32'h0);
        run_op(1'b1, 1'b1, 1'b0, addr + 32'd1, ~data, ACC_HALF, 1'b0, SEL_ALU, 32'h0);
        run_op(1'b1, 1'b1, 1'b0, addr + 32'd3, ~data, ACC_HALF, 1'b0, SEL_ALU, 32'h0);
        for (int ofs = 1; ofs < 4; ofs++)
            run_op(1'b1, 1'b1, 1'b0, addr + 32'(ofs), ~data, ACC_WORD, 1'b0, SEL_ALU, 32'h0);
        run_op(1'b1, 1'b0, 1'b1, addr, 32'h0, ACC_WORD, 1'b0, SEL_MEM, 32'h0);
        run_op(1'b1, 1'b0, 1'b1, addr + 32'd1, 32'h0, ACC_HALF, 1'b0, SEL_MEM, 32'h0);
        run_op(1'b1, 1'b0, 1'b1, addr + 32'd2, 32'h0, ACC_WORD, 1'b0, SEL_MEM, 32'h0);
        report_test("misalignment", err_start);

        err_start = n_errors;
        run_op(1'b1, 1'b0, 1'b0, $urandom, 32'h0, ACC_WORD, 1'b0, SEL_ALU, $urandom);
        run_op(1'b1, 1'b0, 1'b0, $urandom, 32'h0, ACC_WORD, 1'b0, SEL_PC4, $urandom);
        run_op(1'b1, 1'b0, 1'b0, $urandom, 32'h0, ACC_WORD, 1'b0, SEL_PC4, 32'hffff_fffc);
        run_op(1'b1, 1'b0, 1'b0, $urandom, 32'h0, ACC_WORD, 1'b0, wr_data_sel_e'(2'b11), $urandom);
        report_test("write_back_select", err_start);

        // Bubbles neither write nor stall
        err_start = n_errors;
        addr = $urandom & ~32'h3;
        data = $urandom;
        run_op(1'b1, 1'b1, 1'b0, addr, data, ACC_WORD, 1'b0, SEL_ALU, 32'h0);
        run_op(1'b0, 1'b1, 1'b0, addr, ~data, ACC_WORD, 1'b0, SEL_ALU, 32'h0);
        run_op(1'b1, 1'b0, 1'b1, addr, 32'h0, ACC_WORD, 1'b0, SEL_MEM, 32'h0);
        run_op(1'b0, 1'b0, 1'b1, addr, 32'h0, ACC_WORD, 1'b0, SEL_MEM, 32'h0);
        run_op(1'b0, 1'b0, 1'b1, addr, 32'h0, ACC_WORD, 1'b0, SEL_ALU, 32'h0);
        report_test("valid_gating", err_start);

        err_start = n_errors;
        for (int i = 0; i < MIX_OPS; i++) begin
            kind  = int'($urandom_range(3, 0));
            addr  = $urandom;                   // Full width, upper bits wrap
            data  = $urandom;
            pc    = $urandom;
            acc   = data_access_e'(2'($urandom_range(2, 0)));
            sel   = wr_data_sel_e'(2'($urandom_range(3, 0)));
            valid = ($urandom_range(7, 0) != 0);
            case (kind)
                0: run_op(valid, 1'b1, 1'b0, addr, data, acc, 1'b0, sel, pc);
                1: run_op(valid, 1'b0, 1'b1, addr, data, acc, data[31], SEL_MEM, pc);
                2: run_op(valid, 1'b0, 1'b1, addr, data, acc, data[31], sel, pc);
                default: run_op(valid, 1'b0, 1'b0, addr, data, acc, 1'b0, sel, pc);
            endcase
        end
        report_test("random_mix", err_start);

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* sim.f */
+incdir+design
+incdir+dv
design/rv_types_pkg.sv
design/data_mem_adapter.sv
design/data_mem.sv
design/stage_mem.sv
design/mem_subsys_top.sv
dv/tb_mem_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the memory stage testbench with Verilator

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing -f sim.f --top-module tb_mem_subsys -o tb_mem_subsys \
    && ./obj_dir/tb_mem_subsys > "$LOG" 2>&1 \
    || { echo "build or simulation step failed"; cat "$LOG" 2>/dev/null; exit 1; }

cat "$LOG"

# Pass only when the testbench reported success
grep -qx "TEST PASS" "$LOG" && echo "result: pass" || { echo "result: fail"; exit 1; }
